// File: hdl/idu_pkg.sv
package idu_pkg;

    localparam int XLEN        = 32;  // one word
    localparam int REG_ADDR_W  = 5;
    localparam int INST_W      = 32;
    localparam int LINK_OFFSET = 4;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_LUI    = 7'b0110111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NOP, ADD, SUB, SLL, SLT, SLTU, XOR, SRL,
        SRA, OR, AND, AUIPC, LUI, JAL, JALR
    } alu_op_e;

    // msb marks a store
    typedef enum logic [3:0] {
        LS_NOP = 4'h0,
        LB     = 4'h1,
        LH     = 4'h2,
        LW     = 4'h3,
        LBU    = 4'h4,
        LHU    = 4'h5,
        SB     = 4'h9,
        SH     = 4'ha,
        SW     = 4'hb
    } ls_type_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    // alu funct3, same for OP_IMM and OP_REG
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

endpackage

// File: hdl/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import idu_pkg::*; (
    input  logic [INST_W-1:0]     inst_i,
    output logic                  rs1_re_o,
    output logic                  rs2_re_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  reg_we_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output alu_op_e               alu_op_o,
    output logic                  ls_valid_o,
    output ls_type_e              ls_type_o,
    output logic [XLEN-1:0]       mem_offset_o,
    output logic                  is_branch_o,
    output logic                  is_jal_o,
    output logic                  is_jalr_o,
    output logic [2:0]            funct3_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_s_type;
    logic [XLEN-1:0] imm_u_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_j_type;

    // alt is inst[30], picks sub or sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? SUB : ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SR:      op = alt ? SRA : SRL;
            F3_OR:      op = OR;
            F3_AND:     op = AND;
            default:    op = ALU_NOP;
        endcase
        return op;
    endfunction

    assign opcode     = opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_o       = inst_i[11:7];
    assign funct3_o   = funct3;

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign mem_offset_o = ls_type_o[$bits(ls_type_e)-1] ? imm_s_type : imm_i_type;

    always_comb begin
        rs1_re_o    = 1'b0;
        rs2_re_o    = 1'b0;
        reg_we_o    = 1'b0;
        alu_op_o    = ALU_NOP;
        ls_valid_o  = 1'b0;
        ls_type_o   = LS_NOP;
        imm_o       = '0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        case (opcode)
            OP_LOAD: begin
                case (funct3)
                    F3_LB:   ls_type_o = LB;
                    F3_LH:   ls_type_o = LH;
                    F3_LW:   ls_type_o = LW;
                    F3_LBU:  ls_type_o = LBU;
                    F3_LHU:  ls_type_o = LHU;
                    default: ls_type_o = LS_NOP;
                endcase
                ls_valid_o = (ls_type_o != LS_NOP);
                rs1_re_o   = ls_valid_o;
                reg_we_o   = ls_valid_o;
                imm_o      = imm_i_type;
            end
            OP_IMM: begin
                rs1_re_o = 1'b1;
                reg_we_o = 1'b1;
                imm_o    = imm_i_type;
                alu_op_o = alu_sel(funct3, inst_i[30] && (funct3 == F3_SR));  // addi has no sub
            end
            OP_AUIPC: begin
                reg_we_o = 1'b1;
                imm_o    = imm_u_type;
                alu_op_o = AUIPC;
            end
            OP_LUI: begin
                reg_we_o = 1'b1;
                imm_o    = imm_u_type;
                alu_op_o = LUI;
            end
            OP_STORE: begin
                case (funct3)
                    F3_SB:   ls_type_o = SB;
                    F3_SH:   ls_type_o = SH;
                    F3_SW:   ls_type_o = SW;
                    default: ls_type_o = LS_NOP;
                endcase
                ls_valid_o = (ls_type_o != LS_NOP);
                rs1_re_o   = ls_valid_o;
                rs2_re_o   = ls_valid_o;
                imm_o      = imm_s_type;
            end
            OP_REG: begin
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                reg_we_o = 1'b1;
                alu_op_o = alu_sel(funct3, inst_i[30]);
            end
            OP_BRANCH: begin
                if (funct3 inside {BEQ, BNE, BLT, BGE, BLTU, BGEU}) begin
                    rs1_re_o    = 1'b1;
                    rs2_re_o    = 1'b1;
                    imm_o       = imm_b_type;
                    is_branch_o = 1'b1;
                end
            end
            OP_JALR: begin
                rs1_re_o  = 1'b1;
                reg_we_o  = 1'b1;
                imm_o     = imm_i_type;
                alu_op_o  = JALR;
                is_jalr_o = 1'b1;
            end
            OP_JAL: begin
                reg_we_o = 1'b1;
                imm_o    = imm_j_type;
                alu_op_o = JAL;
                is_jal_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import idu_pkg::*; (
    input  logic                  rst_n,
    input  logic                  rs1_re_i,
    input  logic                  rs2_re_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [XLEN-1:0]       reg1_rdata_i,
    input  logic [XLEN-1:0]       reg2_rdata_i,
    input  logic                  exu_reg_we_i,
    input  logic [REG_ADDR_W-1:0] exu_reg_waddr_i,
    input  logic [XLEN-1:0]       exu_reg_wdata_i,
    input  logic                  lsu_reg_we_i,
    input  logic [REG_ADDR_W-1:0] lsu_reg_waddr_i,
    input  logic [XLEN-1:0]       lsu_reg_wdata_i,
    input  logic                  prev_is_load_i,
    output logic [XLEN-1:0]       op1_o,
    output logic [XLEN-1:0]       op2_o,
    output logic                  stall_o
);

    logic rs1_hit;
    logic rs2_hit;

    // ex beats lsu beats regfile, imm when the port is idle
    function automatic logic [XLEN-1:0] pick_operand(
        input logic                  re,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_data
    );
        logic [XLEN-1:0] op;
        if (!re) begin
            op = imm_i;
        end else if (addr == '0) begin
            op = '0;  // x0
        end else if (exu_reg_we_i && (exu_reg_waddr_i == addr)) begin
            op = exu_reg_wdata_i;
        end else if (lsu_reg_we_i && (lsu_reg_waddr_i == addr)) begin
            op = lsu_reg_wdata_i;
        end else begin
            op = rf_data;
        end
        return op;
    endfunction

    always_comb begin
        op1_o = pick_operand(rs1_re_i, rs1_addr_i, reg1_rdata_i);
        op2_o = pick_operand(rs2_re_i, rs2_addr_i, reg2_rdata_i);
    end

    // load data only exists after lsu, so wait one cycle
    assign rs1_hit = rs1_re_i && (rs1_addr_i == exu_reg_waddr_i) && (rs1_addr_i != '0);
    assign rs2_hit = rs2_re_i && (rs2_addr_i == exu_reg_waddr_i) && (rs2_addr_i != '0);
    assign stall_o = prev_is_load_i && (rs1_hit || rs2_hit);

    // a load in EX always brings its register write along
    always_comb begin
        if (rst_n && prev_is_load_i) begin
            assert (exu_reg_we_i) else $error("load in EX without pending register write");
        end
    end

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit import idu_pkg::*; (
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic            is_branch_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic [2:0]      funct3_i,
    input  logic            stall_i,
    output logic            jump_flag_o,
    output logic [XLEN-1:0] jump_addr_o,
    output logic [XLEN-1:0] link_addr_o
);

    logic taken;

    always_comb begin
        case (branch_f3_e'(funct3_i))
            BEQ:     taken = (op1_i == op2_i);
            BNE:     taken = (op1_i != op2_i);
            BLT:     taken = ($signed(op1_i) < $signed(op2_i));
            BGE:     taken = ($signed(op1_i) >= $signed(op2_i));
            BLTU:    taken = (op1_i < op2_i);
            BGEU:    taken = (op1_i >= op2_i);
            default: taken = 1'b0;
        endcase
    end

    // operands are stale while stalled
    assign jump_flag_o = !stall_i && (is_jal_i || is_jalr_i || (is_branch_i && taken));

    assign jump_addr_o = is_jalr_i ? (op1_i + imm_i) : (pc_i + imm_i);
    assign link_addr_o = pc_i + XLEN'(LINK_OFFSET);

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg import idu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       op1_i,
    input  logic [XLEN-1:0]       op2_i,
    input  logic                  reg_we_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  alu_op_e               alu_op_i,
    input  logic                  ls_valid_i,
    input  ls_type_e              ls_type_i,
    input  logic [XLEN-1:0]       mem_offset_i,
    input  logic [XLEN-1:0]       link_addr_i,
    output logic                  ex_valid_o,
    output logic [XLEN-1:0]       ex_pc_o,
    output logic [XLEN-1:0]       ex_op1_o,
    output logic [XLEN-1:0]       ex_op2_o,
    output logic                  ex_reg_we_o,
    output logic [REG_ADDR_W-1:0] ex_reg_waddr_o,
    output alu_op_e               ex_alu_op_o,
    output logic                  ex_ls_valid_o,
    output ls_type_e              ex_ls_type_o,
    output logic [XLEN-1:0]       ex_mem_offset_o,
    output logic [XLEN-1:0]       ex_link_addr_o
);

    always_ff @(posedge clk) begin
        if (!rst_n || stall_i) begin  // bubble on stall
            ex_valid_o    <= 1'b0;
            ex_reg_we_o   <= 1'b0;
            ex_ls_valid_o <= 1'b0;
            ex_alu_op_o   <= ALU_NOP;
            ex_ls_type_o  <= LS_NOP;
        end else begin
            ex_valid_o    <= 1'b1;
            ex_reg_we_o   <= reg_we_i;
            ex_ls_valid_o <= ls_valid_i;
            ex_alu_op_o   <= alu_op_i;
            ex_ls_type_o  <= ls_type_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o         <= pc_i;
        ex_op1_o        <= op1_i;
        ex_op2_o        <= op2_i;
        ex_reg_waddr_o  <= rd_i;
        ex_mem_offset_o <= mem_offset_i;
        ex_link_addr_o  <= link_addr_i;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !ex_valid_o |-> (!ex_reg_we_o && !ex_ls_valid_o))
        else $error("bubble carries a register write or memory access");

    // memory ops never use the alu in this decode
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_ls_valid_o |-> (ex_alu_op_o == ALU_NOP))
        else $error("memory access paired with alu op %0d", ex_alu_op_o);

endmodule

// File: hdl/idu.sv
`timescale 1ns/1ns

module idu import idu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [INST_W-1:0]     inst_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic                  reg1_re_o,
    output logic [REG_ADDR_W-1:0] reg1_raddr_o,
    output logic                  reg2_re_o,
    output logic [REG_ADDR_W-1:0] reg2_raddr_o,
    input  logic [XLEN-1:0]       reg1_rdata_i,
    input  logic [XLEN-1:0]       reg2_rdata_i,
    input  logic                  exu_reg_we_i,
    input  logic [REG_ADDR_W-1:0] exu_reg_waddr_i,
    input  logic [XLEN-1:0]       exu_reg_wdata_i,
    input  logic                  lsu_reg_we_i,
    input  logic [REG_ADDR_W-1:0] lsu_reg_waddr_i,
    input  logic [XLEN-1:0]       lsu_reg_wdata_i,
    input  logic                  prev_is_load_i,
    output logic                  stall_req_o,
    output logic                  jump_flag_o,
    output logic [XLEN-1:0]       jump_addr_o,
    output logic                  ex_valid_o,
    output logic [XLEN-1:0]       ex_pc_o,
    output logic [XLEN-1:0]       ex_op1_o,
    output logic [XLEN-1:0]       ex_op2_o,
    output logic                  ex_reg_we_o,
    output logic [REG_ADDR_W-1:0] ex_reg_waddr_o,
    output alu_op_e               ex_alu_op_o,
    output logic                  ex_ls_valid_o,
    output ls_type_e              ex_ls_type_o,
    output logic [XLEN-1:0]       ex_mem_offset_o,
    output logic [XLEN-1:0]       ex_link_addr_o
);

    logic [XLEN-1:0]       imm;
    logic                  reg_we;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
    logic                  ls_valid;
    ls_type_e              ls_type;
    logic [XLEN-1:0]       mem_offset;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [XLEN-1:0]       link_addr;

    inst_decoder u_dec (
        .inst_i       (inst_i),
        .rs1_re_o     (reg1_re_o),    .rs2_re_o     (reg2_re_o),
        .rs1_addr_o   (reg1_raddr_o), .rs2_addr_o   (reg2_raddr_o),
        .imm_o        (imm),          .reg_we_o     (reg_we),
        .rd_o         (rd),           .alu_op_o     (alu_op),
        .ls_valid_o   (ls_valid),     .ls_type_o    (ls_type),
        .mem_offset_o (mem_offset),   .is_branch_o  (is_branch),
        .is_jal_o     (is_jal),       .is_jalr_o    (is_jalr),
        .funct3_o     (funct3)
    );

    hazard_unit u_haz (
        .rst_n           (rst_n),
        .rs1_re_i        (reg1_re_o),       .rs2_re_i        (reg2_re_o),
        .rs1_addr_i      (reg1_raddr_o),    .rs2_addr_i      (reg2_raddr_o),
        .imm_i           (imm),
        .reg1_rdata_i    (reg1_rdata_i),    .reg2_rdata_i    (reg2_rdata_i),
        .exu_reg_we_i    (exu_reg_we_i),    .exu_reg_waddr_i (exu_reg_waddr_i),
        .exu_reg_wdata_i (exu_reg_wdata_i),
        .lsu_reg_we_i    (lsu_reg_we_i),    .lsu_reg_waddr_i (lsu_reg_waddr_i),
        .lsu_reg_wdata_i (lsu_reg_wdata_i),
        .prev_is_load_i  (prev_is_load_i),
        .op1_o           (op1),             .op2_o           (op2),
        .stall_o         (stall_req_o)
    );

    branch_unit u_br (
        .pc_i        (pc_i),        .op1_i       (op1),
        .op2_i       (op2),         .imm_i       (imm),
        .is_branch_i (is_branch),   .is_jal_i    (is_jal),
        .is_jalr_i   (is_jalr),     .funct3_i    (funct3),
        .stall_i     (stall_req_o),
        .jump_flag_o (jump_flag_o), .jump_addr_o (jump_addr_o),
        .link_addr_o (link_addr)
    );

    id_ex_reg u_idex (
        .clk             (clk),             .rst_n           (rst_n),
        .stall_i         (stall_req_o),     .pc_i            (pc_i),
        .op1_i           (op1),             .op2_i           (op2),
        .reg_we_i        (reg_we),          .rd_i            (rd),
        .alu_op_i        (alu_op),          .ls_valid_i      (ls_valid),
        .ls_type_i       (ls_type),         .mem_offset_i    (mem_offset),
        .link_addr_i     (link_addr),       .ex_valid_o      (ex_valid_o),
        .ex_pc_o         (ex_pc_o),         .ex_op1_o        (ex_op1_o),
        .ex_op2_o        (ex_op2_o),        .ex_reg_we_o     (ex_reg_we_o),
        .ex_reg_waddr_o  (ex_reg_waddr_o),  .ex_alu_op_o     (ex_alu_op_o),
        .ex_ls_valid_o   (ex_ls_valid_o),   .ex_ls_type_o    (ex_ls_type_o),
        .ex_mem_offset_o (ex_mem_offset_o), .ex_link_addr_o  (ex_link_addr_o)
    );

    // a stalled instruction must not redirect fetch
    assert property (@(posedge clk) disable iff (!rst_n) !(stall_req_o && jump_flag_o))
        else $error("jump raised during load-use stall");

endmodule

// File: sim/tb_idu.sv
`timescale 1ns/1ns

module tb_idu import idu_pkg::*; ();

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rf [32];
    logic        exu_we;
    logic [4:0]  exu_waddr;
    logic [31:0] exu_wdata;
    logic        lsu_we;
    logic [4:0]  lsu_waddr;
    logic [31:0] lsu_wdata;
    logic        prev_load;
    logic        reg1_re;
    logic        reg2_re;
    logic [4:0]  reg1_raddr;
    logic [4:0]  reg2_raddr;
    logic [31:0] reg1_rdata;
    logic [31:0] reg2_rdata;
    logic        stall_req;
    logic        jump_flag;
    logic [31:0] jump_addr;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic [31:0] ex_op1;
    logic [31:0] ex_op2;
    logic        ex_reg_we;
    logic [4:0]  ex_reg_waddr;
    alu_op_e     ex_alu_op;
    logic        ex_ls_valid;
    ls_type_e    ex_ls_type;
    logic [31:0] ex_mem_offset;
    logic [31:0] ex_link_addr;

    // model outputs, m_ for this cycle, q_ for the register stage
    logic        m_re1, m_re2, m_we, m_lsv, m_br, m_jal, m_jalr, m_stall, m_jump;
    logic [31:0] m_imm, m_off, m_op1, m_op2, m_jaddr;
    alu_op_e     m_alu;
    ls_type_e    m_lst;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]  d_f3;
    logic        q_valid = 1'b0;
    logic        q_we = 1'b0;
    logic        q_lsv = 1'b0;
    alu_op_e     q_alu = ALU_NOP;
    ls_type_e    q_lst = LS_NOP;
    logic [4:0]  q_rd;
    logic [31:0] q_pc, q_op1, q_op2, q_off, q_link;
    int          errors = 0;
    int          timeouts = 0;

    idu DUT (
        .clk             (clk),           .rst_n           (rst_n),
        .inst_i          (inst),          .pc_i            (pc),
        .reg1_re_o       (reg1_re),       .reg1_raddr_o    (reg1_raddr),
        .reg2_re_o       (reg2_re),       .reg2_raddr_o    (reg2_raddr),
        .reg1_rdata_i    (reg1_rdata),    .reg2_rdata_i    (reg2_rdata),
        .exu_reg_we_i    (exu_we),        .exu_reg_waddr_i (exu_waddr),
        .exu_reg_wdata_i (exu_wdata),     .lsu_reg_we_i    (lsu_we),
        .lsu_reg_waddr_i (lsu_waddr),     .lsu_reg_wdata_i (lsu_wdata),
        .prev_is_load_i  (prev_load),     .stall_req_o     (stall_req),
        .jump_flag_o     (jump_flag),     .jump_addr_o     (jump_addr),
        .ex_valid_o      (ex_valid),      .ex_pc_o         (ex_pc),
        .ex_op1_o        (ex_op1),        .ex_op2_o        (ex_op2),
        .ex_reg_we_o     (ex_reg_we),     .ex_reg_waddr_o  (ex_reg_waddr),
        .ex_alu_op_o     (ex_alu_op),     .ex_ls_valid_o   (ex_ls_valid),
        .ex_ls_type_o    (ex_ls_type),    .ex_mem_offset_o (ex_mem_offset),
        .ex_link_addr_o  (ex_link_addr)
    );

    // register file answers in the same cycle
    assign reg1_rdata = rf[reg1_raddr];
    assign reg2_rdata = rf[reg2_raddr];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic alu_op_e alu_kind(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? SUB : ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return alt ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic ls_type_e ls_kind(input logic store, input logic [2:0] f3);
        case ({store, f3})
            4'b0000: return LB;
            4'b0001: return LH;
            4'b0010: return LW;
            4'b0100: return LBU;
            4'b0101: return LHU;
            4'b1000: return SB;
            4'b1001: return SH;
            4'b1010: return SW;
            default: return LS_NOP;
        endcase
    endfunction

    function automatic logic [31:0] operand(input logic re, input logic [4:0] a,
                                            input logic [31:0] imm, input logic [31:0] rf_val);
        if (!re) return imm;
        if (a == 5'd0) return 32'd0;
        if (exu_we && exu_waddr == a) return exu_wdata;
        if (lsu_we && lsu_waddr == a) return lsu_wdata;
        return rf_val;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    always_comb begin
        d_f3   = inst[14:12];
        imm_i  = {{20{inst[31]}}, inst[31:20]};
        imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u  = {inst[31:12], 12'd0};
        imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        m_re1  = 1'b0;
        m_re2  = 1'b0;
        m_we   = 1'b0;
        m_lsv  = 1'b0;
        m_br   = 1'b0;
        m_jal  = 1'b0;
        m_jalr = 1'b0;
        m_imm  = 32'd0;
        m_alu  = ALU_NOP;
        m_lst  = LS_NOP;
        case (inst[6:0])
            OPC_LOAD, OPC_STORE: begin
                m_lst = ls_kind(inst[5], d_f3);  // bit 5 set for stores
                m_lsv = (m_lst != LS_NOP);
                m_re1 = m_lsv;
                m_re2 = m_lsv && inst[5];
                m_we  = m_lsv && !inst[5];
                m_imm = inst[5] ? imm_s : imm_i;
            end
            OPC_IMM: begin
                m_re1 = 1'b1;
                m_we  = 1'b1;
                m_imm = imm_i;
                m_alu = alu_kind(d_f3, inst[30] && d_f3 == 3'd5);
            end
            OPC_REG: begin
                m_re1 = 1'b1;
                m_re2 = 1'b1;
                m_we  = 1'b1;
                m_alu = alu_kind(d_f3, inst[30]);
            end
            OPC_LUI, OPC_AUIPC: begin
                m_we  = 1'b1;
                m_imm = imm_u;
                m_alu = inst[5] ? LUI : AUIPC;
            end
            OPC_BRANCH: begin
                m_br  = (d_f3[2:1] != 2'b01);
                m_re1 = m_br;
                m_re2 = m_br;
                m_imm = m_br ? imm_b : 32'd0;
            end
            OPC_JALR: begin
                m_re1  = 1'b1;
                m_we   = 1'b1;
                m_imm  = imm_i;
                m_alu  = JALR;
                m_jalr = 1'b1;
            end
            OPC_JAL: begin
                m_we  = 1'b1;
                m_imm = imm_j;
                m_alu = JAL;
                m_jal = 1'b1;
            end
            default: ;
        endcase
        m_off   = (inst[6:0] == OPC_STORE) ? imm_s : imm_i;
        m_op1   = operand(m_re1, inst[19:15], m_imm, rf[inst[19:15]]);
        m_op2   = operand(m_re2, inst[24:20], m_imm, rf[inst[24:20]]);
        m_stall = prev_load && ((m_re1 && inst[19:15] == exu_waddr && inst[19:15] != 5'd0) ||
                                (m_re2 && inst[24:20] == exu_waddr && inst[24:20] != 5'd0));
        m_jump  = !m_stall && (m_jal || m_jalr || (m_br && branch_taken(d_f3, m_op1, m_op2)));
        m_jaddr = m_jalr ? m_op1 + m_imm : pc + m_imm;
    end

    always @(posedge clk) begin
        q_valid <= rst_n && !m_stall;
        q_we    <= rst_n && !m_stall && m_we;
        q_lsv   <= rst_n && !m_stall && m_lsv;
        q_alu   <= (rst_n && !m_stall) ? m_alu : ALU_NOP;
        q_lst   <= (rst_n && !m_stall) ? m_lst : LS_NOP;
        q_rd    <= inst[11:7];
        q_pc    <= pc;
        q_op1   <= m_op1;
        q_op2   <= m_op2;
        q_off   <= m_off;
        q_link  <= pc + 32'd4;
    end

    task automatic note_mismatch(input string what);
        errors++;
        $display("Fail %0t: %s", $time, what);
    endtask

    assert property (@(posedge clk) $rose(rst_n) |->
        (!ex_valid && !ex_reg_we && !ex_ls_valid && ex_alu_op == ALU_NOP))
        else note_mismatch("register stage not cleared by reset");
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid == q_valid && ex_reg_we == q_we && ex_ls_valid == q_lsv)
        else note_mismatch("ex valid/reg_we/ls_valid differ from model");
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_alu_op == q_alu && ex_ls_type == q_lst)
        else note_mismatch("ex alu_op or ls_type differ from model");
    assert property (@(posedge clk) disable iff (!rst_n)
        q_valid |-> (ex_op1 == q_op1 && ex_op2 == q_op2))
        else note_mismatch("ex operands differ from model");
    assert property (@(posedge clk) disable iff (!rst_n)
        q_valid |-> (ex_reg_waddr == q_rd && ex_pc == q_pc && ex_link_addr == q_link))
        else note_mismatch("ex rd, pc or link address differ from model");
    assert property (@(posedge clk) disable iff (!rst_n) q_valid |-> ex_mem_offset == q_off)
        else note_mismatch("ex mem offset differs from model");
    assert property (@(posedge clk) disable iff (!rst_n)
        reg1_re == m_re1 && reg2_re == m_re2 && stall_req == m_stall)
        else note_mismatch("read enables or stall request differ from model");
    assert property (@(posedge clk) disable iff (!rst_n)
        (!m_re1 || reg1_raddr == inst[19:15]) && (!m_re2 || reg2_raddr == inst[24:20]))
        else note_mismatch("read addresses differ from instruction fields");
    assert property (@(posedge clk) disable iff (!rst_n) jump_flag == m_jump)
        else note_mismatch("jump flag differs from model");
    assert property (@(posedge clk) disable iff (!rst_n) jump_flag |-> jump_addr == m_jaddr)
        else note_mismatch("jump address differs from model");

    function automatic logic [31:0] make_inst(input logic [6:0] opc, input logic [2:0] f3);
        logic [31:0] w;
        w        = $urandom;
        w[14:12] = f3;
        w[6:0]   = opc;
        return w;
    endfunction

    task automatic clear_forwarding();
        exu_we    = 1'b0;
        exu_waddr = 5'd0;
        exu_wdata = 32'd0;
        lsu_we    = 1'b0;
        lsu_waddr = 5'd0;
        lsu_wdata = 32'd0;
        prev_load = 1'b0;
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        while (ex_valid !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (ex_valid !== 1'b1) begin
            timeouts++;
            $display("timed out after %0d cycles waiting for ex_valid_o", limit);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        void'($urandom(32'h1480c864));
        rst_n = 1'b0;
        inst  = 32'h0000_0013;  // addi x0, x0, 0
        pc    = 32'd0;
        clear_forwarding();
        for (int k = 0; k < 32; k++) begin
            rf[k] = (k == 0) ? 32'd0 : $urandom;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        wait_valid(8);

        repeat (40) begin  // alu decode
            @(negedge clk);
            r = $urandom;
            case (r[1:0])
                2'd0:    inst = make_inst(OPC_REG, r[4:2]);
                2'd1:    inst = make_inst(OPC_IMM, r[4:2]);
                2'd2:    inst = make_inst(OPC_LUI, r[4:2]);
                default: inst = make_inst(OPC_AUIPC, r[4:2]);
            endcase
            pc = $urandom & 32'hffff_fffc;
        end

        repeat (30) begin  // forwarding priority
            @(negedge clk);
            r         = $urandom;
            inst      = make_inst(OPC_REG, r[2:0]);
            exu_we    = r[3];
            lsu_we    = r[4];
            exu_waddr = r[5] ? inst[19:15] : inst[24:20];
            lsu_waddr = r[6] ? inst[19:15] : inst[24:20];
            exu_wdata = $urandom;
            lsu_wdata = $urandom;
            if (r[9:7] == 3'd0) begin  // x0 ignores a pending write
                inst[19:15] = 5'd0;
                exu_waddr   = 5'd0;
                exu_we      = 1'b1;
            end
        end

        repeat (6) begin  // load-use, held two cycles then released
            @(negedge clk);
            r    = $urandom;
            inst = make_inst(r[0] ? OPC_JALR : OPC_REG, 3'd0);
            if (inst[19:15] == 5'd0) begin
                inst[19:15] = 5'd7;
            end
            prev_load = 1'b1;
            exu_we    = 1'b1;
            exu_waddr = (r[0] || r[1]) ? inst[19:15] : inst[24:20];
            lsu_we    = 1'b0;
            repeat (2) @(negedge clk);
            clear_forwarding();
            wait_valid(4);
        end

        repeat (60) begin  // branches and jumps
            @(negedge clk);
            r  = $urandom;
            f3 = (r[2:1] == 2'b01) ? {1'b1, r[1:0]} : r[2:0];
            case (r[5:4])
                2'd2:    inst = make_inst(OPC_JAL, f3);
                2'd3:    inst = make_inst(OPC_JALR, 3'd0);
                default: inst = make_inst(OPC_BRANCH, f3);
            endcase
            if (r[6]) begin
                inst[24:20] = inst[19:15];  // equal operands
            end
            pc = $urandom & 32'hffff_fffc;
        end

        repeat (40) begin  // loads and stores
            @(negedge clk);
            r = $urandom;
            if (r[3]) begin
                inst = make_inst(OPC_STORE, (r[1:0] == 2'd3) ? 3'd2 : {1'b0, r[1:0]});
            end else begin
                inst = make_inst(OPC_LOAD, (r[2:0] inside {3'd3, 3'd6, 3'd7}) ? 3'd2 : r[2:0]);
            end
        end

        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/idu_pkg.sv
hdl/inst_decoder.sv
hdl/hazard_unit.sv
hdl/branch_unit.sv
hdl/id_ex_reg.sv
hdl/idu.sv
sim/tb_idu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --assert -f compile.f --top-module tb_idu -o tb_idu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_idu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
